// File: vlog.f
src/uart_pkg.sv
src/uart_ctrl_if.sv
src/uart_stat_if.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_irq.sv
src/uart_core.sv
src/uart_reg_decode.sv
src/uart_top.sv
tb/uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module uart_tb \
  -f vlog.f \
  -o uart_tb_sim

./obj_dir/uart_tb_sim

// File: tb/uart_tb.sv
`timescale 1ns/1ps

module uart_tb;

  localparam int FifoDepth = 8;
  localparam int PollLimit = 2000;
  // nco 0x8000 gives a tick every 2 cycles, so one bit is 32 cycles
  localparam int BitCycles = 32;
  localparam logic [31:0] NcoBits = 32'h8000_0000;

  // register map, kept separately from the design package
  localparam logic [7:0] AddrCtrl       = 8'h00;
  localparam logic [7:0] AddrStatus     = 8'h04;
  localparam logic [7:0] AddrWdata      = 8'h08;
  localparam logic [7:0] AddrRdata      = 8'h0C;
  localparam logic [7:0] AddrFifoCtrl   = 8'h10;
  localparam logic [7:0] AddrIntrState  = 8'h14;
  localparam logic [7:0] AddrIntrEnable = 8'h18;
  localparam logic [7:0] AddrFifoStatus = 8'h1C;

  logic        clk_i;
  logic        rst_ni;
  logic [7:0]  paddr_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic        rx_i;
  logic        tx_o;
  logic        intr_o;

  logic [31:0] lfsr_q;
  logic        lpbk_on;
  logic [7:0]  exp_q[$];

  uart_top #(
    .FifoDepth(FifoDepth)
  ) dut_i (
    .clk_i,
    .rst_ni,
    .paddr_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .rx_i,
    .tx_o,
    .intr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // failure reporting and random bytes
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic fail_value(input string msg);
    $display("[FAIL] %0t %s", $time, msg);
    stop_run();
  endtask

  task automatic timed_out(input string what);
    $display("timed out at %0t while waiting for %s", $time, what);
    stop_run();
  endtask

  // fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [7:0] next_byte();
    logic [7:0] b;
    b = '0;
    for (int i = 0; i < 8; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      b = {b[6:0], lfsr_q[0]};
    end
    return b;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // APB master
  //////////////////////////////////////////////////////////////////////

  task automatic apb_xfer(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    #1;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pwrite_i  = wr;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(posedge clk_i);
    #1;
    penable_i = 1'b1;
    // sample mid access phase, before the completing edge
    #2;
    rdata = prdata_o;
    err   = pslverr_o;
    @(posedge clk_i);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    logic        err;
    apb_xfer(addr, 1'b1, data, unused, err);
    assert (!err) else fail_value($sformatf("pslverr on write to 0x%02h", addr));
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(addr, 1'b0, 32'h0, data, err);
    assert (!err) else fail_value($sformatf("pslverr on read of 0x%02h", addr));
  endtask

  task automatic check_reg(input logic [7:0] addr, input logic [31:0] mask,
                           input logic [31:0] exp);
    logic [31:0] got;
    read_reg(addr, got);
    assert ((got & mask) == exp)
      else fail_value($sformatf("reg 0x%02h read 0x%08h, expected 0x%08h",
                                addr, got & mask, exp));
  endtask

  task automatic poll_reg(input logic [7:0] addr, input logic [31:0] mask,
                          input logic [31:0] exp, input string what);
    logic [31:0] got;
    int          n;
    n = 0;
    read_reg(addr, got);
    while ((got & mask) != exp) begin
      n++;
      if (n > PollLimit) timed_out(what);
      read_reg(addr, got);
    end
  endtask

  // intr_o must equal the OR of state AND enable
  task automatic check_intr_line(input logic [3:0] st_exp, input logic [3:0] en_exp);
    check_reg(AddrIntrState, '1, {28'b0, st_exp});
    check_reg(AddrIntrEnable, '1, {28'b0, en_exp});
    @(negedge clk_i);
    assert (intr_o == |(st_exp & en_exp))
      else fail_value($sformatf("intr_o %0b with state 0x%h enable 0x%h", intr_o,
                                st_exp, en_exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // serial line monitor and driver
  //////////////////////////////////////////////////////////////////////

  task automatic capture_tx_frame(output logic [7:0] data);
    int n;
    n    = 0;
    data = '0;
    @(negedge clk_i);
    while (tx_o) begin
      n++;
      if (n > 4 * PollLimit) timed_out("start bit on tx_o");
      @(negedge clk_i);
    end
    // step to mid-bit, then one bit period per sample
    repeat (BitCycles / 2) @(negedge clk_i);
    assert (!tx_o) else fail_value("start bit on tx_o ended early");
    for (int i = 0; i < 8; i++) begin
      repeat (BitCycles) @(negedge clk_i);
      data[i] = tx_o;
    end
    repeat (BitCycles) @(negedge clk_i);
    assert (tx_o) else fail_value("stop bit on tx_o is 0");
  endtask

  task automatic drive_rx_frame(input logic [7:0] data, input logic stop);
    logic [9:0] frame;
    frame = {stop, data, 1'b0};
    @(posedge clk_i);
    #1;
    for (int i = 0; i < 10; i++) begin
      rx_i = frame[i];
      repeat (BitCycles) @(posedge clk_i);
      #1;
    end
    rx_i = 1'b1;
    repeat (BitCycles) @(posedge clk_i);
    #1;
  endtask

  a_lpbk_line_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lpbk_on |-> tx_o)
    else fail_value("tx_o left the idle level during system loopback");

  a_pready_high: assert property (@(posedge clk_i) disable iff (!rst_ni) pready_o)
    else fail_value("pready_o low");

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rd;
    logic [31:0] dummy;
    logic [7:0]  b;
    logic [7:0]  got;
    logic        err;

    rst_ni    = 1'b0;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    rx_i      = 1'b1;
    lpbk_on   = 1'b0;
    lfsr_q    = 32'h4d388fe1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // reset values, readback and unmapped addresses
    check_reg(AddrStatus, '1, 32'h3C);
    check_reg(AddrCtrl, '1, 32'h0);
    check_reg(AddrRdata, '1, 32'h0);
    check_reg(AddrIntrState, '1, 32'h0);
    check_reg(AddrIntrEnable, '1, 32'h0);
    check_reg(AddrFifoStatus, '1, 32'h0);
    @(negedge clk_i);
    assert (!intr_o) else fail_value("intr_o set after reset");
    write_reg(AddrCtrl, 32'h5a5a_0003);
    check_reg(AddrCtrl, '1, 32'h5a5a_0003);
    apb_xfer(8'h20, 1'b0, 32'h0, dummy, err);
    assert (err) else fail_value("no pslverr on unmapped read");
    apb_xfer(8'h24, 1'b1, 32'h0, dummy, err);
    assert (err) else fail_value("no pslverr on unmapped write");

    // system loopback of a full FIFO of bytes
    write_reg(AddrCtrl, NcoBits | 32'h7);
    lpbk_on = 1'b1;
    for (int i = 0; i < FifoDepth; i++) begin
      b = next_byte();
      exp_q.push_back(b);
      write_reg(AddrWdata, {24'b0, b});
    end
    poll_reg(AddrFifoStatus, 32'h00ff_0000, 32'(FifoDepth) << 16, "loopback RX level");
    while (exp_q.size() > 0) begin
      b = exp_q.pop_front();
      read_reg(AddrRdata, rd);
      assert (rd == {24'b0, b})
        else fail_value($sformatf("RDATA 0x%08h, expected 0x%02h", rd, b));
    end
    poll_reg(AddrStatus, 32'h10, 32'h10, "txidle after loopback");

    // external transmit
    lpbk_on = 1'b0;
    write_reg(AddrCtrl, NcoBits | 32'h3);
    write_reg(AddrIntrState, 32'hf);
    b = next_byte();
    write_reg(AddrWdata, {24'b0, b});
    capture_tx_frame(got);
    assert (got == b) else fail_value($sformatf("tx_o byte 0x%02h, expected 0x%02h", got, b));
    poll_reg(AddrStatus, 32'h10, 32'h10, "txidle after transmit");
    check_reg(AddrIntrState, 32'h1, 32'h1);

    // external receive, good frame then bad stop bit
    write_reg(AddrIntrState, 32'hf);
    b = next_byte();
    drive_rx_frame(b, 1'b1);
    poll_reg(AddrFifoStatus, 32'h00ff_0000, 32'h0001_0000, "received byte");
    check_reg(AddrIntrState, 32'h2, 32'h2);
    check_reg(AddrRdata, '1, {24'b0, b});
    write_reg(AddrIntrState, 32'hf);
    drive_rx_frame(next_byte(), 1'b0);
    poll_reg(AddrIntrState, 32'h8, 32'h8, "frame error interrupt");
    check_reg(AddrFifoStatus, 32'h00ff_0000, 32'h0);

    // RX overflow in loopback, then TX back-pressure with the engine stopped
    write_reg(AddrIntrState, 32'hf);
    write_reg(AddrCtrl, NcoBits | 32'h7);
    lpbk_on = 1'b1;
    for (int i = 0; i <= FifoDepth; i++) begin
      write_reg(AddrWdata, {24'b0, next_byte()});
    end
    poll_reg(AddrIntrState, 32'h4, 32'h4, "RX overflow interrupt");
    check_reg(AddrFifoStatus, 32'h00ff_0000, 32'(FifoDepth) << 16);
    poll_reg(AddrStatus, 32'h10, 32'h10, "txidle after overflow");
    write_reg(AddrCtrl, NcoBits | 32'h6);
    for (int i = 0; i < FifoDepth; i++) begin
      write_reg(AddrWdata, {24'b0, next_byte()});
    end
    check_reg(AddrStatus, 32'h1, 32'h1);
    apb_xfer(AddrWdata, 1'b1, 32'h0000_00a5, dummy, err);
    assert (err) else fail_value("no pslverr on write into full TX FIFO");
    check_reg(AddrFifoStatus, 32'h0000_00ff, 32'(FifoDepth));

    // interrupt output, W1C and FIFO clear
    // tx_empty, rx_watermark and rx_overflow are pending from the overflow run
    write_reg(AddrIntrEnable, 32'h0);
    check_intr_line(4'h7, 4'h0);
    write_reg(AddrIntrEnable, 32'h4);
    check_intr_line(4'h7, 4'h4);
    write_reg(AddrIntrState, 32'h4);
    check_intr_line(4'h3, 4'h4);
    write_reg(AddrIntrEnable, 32'hf);
    check_intr_line(4'h3, 4'hf);
    write_reg(AddrIntrState, 32'hf);
    check_intr_line(4'h0, 4'hf);
    write_reg(AddrFifoCtrl, 32'h3);
    check_reg(AddrFifoStatus, '1, 32'h0);
    check_reg(AddrStatus, '1, 32'h3C);

    lpbk_on = 1'b0;
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: src/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // APB slave
  input  logic [7:0]  paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  // serial line and interrupt
  input  logic        rx_i,
  output logic        tx_o,
  output logic        intr_o
);

  logic [NumIntr-1:0] intr_state;
  logic [NumIntr-1:0] intr_enable;
  logic [NumIntr-1:0] intr_clr;

  uart_ctrl_if ctrl_if ();
  uart_stat_if #(.FifoDepth(FifoDepth)) stat_if ();

  uart_reg_decode #(
    .FifoDepth(FifoDepth)
  ) u_decode (
    .clk_i,
    .rst_ni,
    .paddr_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .ctrl         (ctrl_if.dec),
    .stat         (stat_if.dec),
    .intr_state_i (intr_state),
    .intr_enable_o(intr_enable),
    .intr_clr_o   (intr_clr)
  );

  uart_core #(
    .FifoDepth(FifoDepth)
  ) u_core (
    .clk_i,
    .rst_ni,
    .rx_i,
    .tx_o,
    .ctrl(ctrl_if.core),
    .stat(stat_if.core)
  );

  uart_irq u_irq (
    .clk_i,
    .rst_ni,
    .stat         (stat_if.irq),
    .intr_enable_i(intr_enable),
    .intr_clr_i   (intr_clr),
    .intr_state_o (intr_state),
    .intr_o
  );

endmodule

// File: src/uart_reg_decode.sv
`timescale 1ns/1ps

module uart_reg_decode import uart_pkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [7:0]         paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  logic [31:0]        pwdata_i,
  output logic [31:0]        prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  uart_ctrl_if.dec           ctrl,
  uart_stat_if.dec           stat,
  input  logic [NumIntr-1:0] intr_state_i,
  output logic [NumIntr-1:0] intr_enable_o,
  output logic [NumIntr-1:0] intr_clr_o
);

  localparam int LvlW = $clog2(FifoDepth) + 1;

  uart_reg_e          reg_addr;
  logic               access;
  logic               wr_en;
  logic               rd_en;
  logic               mapped;
  logic               tx_en_q;
  logic               rx_en_q;
  logic               lpbk_q;
  logic [15:0]        nco_q;
  logic [NumIntr-1:0] intr_en_q;

  assign reg_addr = uart_reg_e'(paddr_i);

  // transfers complete in the access phase, no wait states
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign rd_en    = access & ~pwrite_i;
  assign pready_o = 1'b1;

  //////////////////////////////////////////////////////////////////////
  // register storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_en_q   <= 1'b0;
      rx_en_q   <= 1'b0;
      lpbk_q    <= 1'b0;
      nco_q     <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      if (reg_addr == CTRL) begin
        tx_en_q <= pwdata_i[0];
        rx_en_q <= pwdata_i[1];
        lpbk_q  <= pwdata_i[2];
        nco_q   <= pwdata_i[31:16];
      end
      if (reg_addr == INTR_ENABLE) begin
        intr_en_q <= pwdata_i[NumIntr-1:0];
      end
    end
  end

  assign ctrl.tx_en     = tx_en_q;
  assign ctrl.rx_en     = rx_en_q;
  assign ctrl.sys_lpbk  = lpbk_q;
  assign ctrl.nco       = nco_q;
  assign intr_enable_o  = intr_en_q;

  //////////////////////////////////////////////////////////////////////
  // command pulses
  //////////////////////////////////////////////////////////////////////

  // a write into a full TX FIFO is dropped and flagged below
  assign ctrl.tx_push  = wr_en & (reg_addr == WDATA) & ~stat.tx_full;
  assign ctrl.tx_wdata = pwdata_i[7:0];
  assign ctrl.rx_pop   = rd_en & (reg_addr == RDATA);
  assign ctrl.rx_clr   = wr_en & (reg_addr == FIFO_CTRL) & pwdata_i[0];
  assign ctrl.tx_clr   = wr_en & (reg_addr == FIFO_CTRL) & pwdata_i[1];
  assign intr_clr_o    = (wr_en && reg_addr == INTR_STATE) ? pwdata_i[NumIntr-1:0] : '0;

  // read mux, write-only registers read as zero
  always_comb begin
    mapped   = 1'b1;
    prdata_o = '0;
    case (reg_addr)
      CTRL:        prdata_o = {nco_q, 13'b0, lpbk_q, rx_en_q, tx_en_q};
      STATUS:      prdata_o = {26'b0, stat.rx_idle, stat.tx_idle, ~stat.rx_valid,
                               stat.tx_level == '0, stat.rx_full, stat.tx_full};
      RDATA:       prdata_o = {24'b0, stat.rx_valid ? stat.rx_rdata : 8'h00};
      INTR_STATE:  prdata_o = {{(32-NumIntr){1'b0}}, intr_state_i};
      INTR_ENABLE: prdata_o = {{(32-NumIntr){1'b0}}, intr_en_q};
      FIFO_STATUS: prdata_o = {8'h00, {(8-LvlW){1'b0}}, stat.rx_level,
                               8'h00, {(8-LvlW){1'b0}}, stat.tx_level};
      WDATA,
      FIFO_CTRL:   prdata_o = '0;
      default:     mapped = 1'b0;
    endcase
  end

  assign pslverr_o = access & (~mapped | (pwrite_i & (reg_addr == WDATA) & stat.tx_full));

  // the master must not raise penable outside a selected transfer
  a_penable_psel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    penable_i |-> psel_i)
    else $error("[FAIL] %0t penable_i high without psel_i", $time);

endmodule

// File: src/uart_core.sv
`timescale 1ns/1ps

module uart_core import uart_pkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       rx_i,
  output logic       tx_o,
  uart_ctrl_if.core  ctrl,
  uart_stat_if.core  stat
);

  logic [NcoWidth:0] nco_sum_q;
  logic              tick;
  logic [1:0]        rx_sync_q;
  logic              rx_line;
  logic              tx_bit;
  logic              tx_q;
  logic [7:0]        tx_head;
  logic              tx_head_valid;
  logic              tx_start;
  logic              tx_eng_idle;
  logic [7:0]        rx_byte;

  //////////////////////////////////////////////////////////////////////
  // baud generator, one tick per carry at 16x the bit rate
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nco_sum_q <= '0;
    end else if (ctrl.tx_en || ctrl.rx_en) begin
      nco_sum_q <= {1'b0, nco_sum_q[NcoWidth-1:0]} + {1'b0, ctrl.nco};
    end
  end

  assign tick = nco_sum_q[NcoWidth];

  //////////////////////////////////////////////////////////////////////
  // transmit path
  //////////////////////////////////////////////////////////////////////

  // take the next byte as soon as the engine is free
  assign tx_start = tx_eng_idle & ctrl.tx_en & tx_head_valid;

  uart_fifo #(.FifoDepth(FifoDepth)) u_tx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i  (ctrl.tx_clr),
    .push_i (ctrl.tx_push),
    .data_i (ctrl.tx_wdata),
    .pop_i  (tx_start),
    .data_o (tx_head),
    .valid_o(tx_head_valid),
    .full_o (stat.tx_full),
    .level_o(stat.tx_level)
  );

  uart_tx u_tx (
    .clk_i,
    .rst_ni,
    .tick_i (tick),
    .start_i(tx_start),
    .data_i (tx_head),
    .idle_o (tx_eng_idle),
    .bit_o  (tx_bit)
  );

  assign stat.tx_idle = tx_eng_idle & ~tx_head_valid;
  assign stat.tx_busy = ~tx_eng_idle;

  // line held at mark while looped back internally
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_q <= 1'b1;
    end else begin
      tx_q <= ctrl.sys_lpbk | tx_bit;
    end
  end

  assign tx_o = tx_q;

  //////////////////////////////////////////////////////////////////////
  // receive path
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_sync_q <= 2'b11;
    end else begin
      rx_sync_q <= {rx_sync_q[0], rx_i};
    end
  end

  assign rx_line = ctrl.sys_lpbk ? tx_bit : rx_sync_q[1];

  uart_rx u_rx (
    .clk_i,
    .rst_ni,
    .en_i       (ctrl.rx_en),
    .tick_i     (tick),
    .line_i     (rx_line),
    .valid_o    (stat.rx_push),
    .frame_err_o(stat.rx_frame_err),
    .data_o     (rx_byte),
    .idle_o     (stat.rx_idle)
  );

  // a push into a full FIFO is dropped there and counts as overflow
  uart_fifo #(.FifoDepth(FifoDepth)) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i  (ctrl.rx_clr),
    .push_i (stat.rx_push),
    .data_i (rx_byte),
    .pop_i  (ctrl.rx_pop),
    .data_o (stat.rx_rdata),
    .valid_o(stat.rx_valid),
    .full_o (stat.rx_full),
    .level_o(stat.rx_level)
  );

endmodule

// File: src/uart_irq.sv
`timescale 1ns/1ps

module uart_irq import uart_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  uart_stat_if.irq           stat,
  input  logic [NumIntr-1:0] intr_enable_i,
  input  logic [NumIntr-1:0] intr_clr_i,
  output logic [NumIntr-1:0] intr_state_o,
  output logic               intr_o
);

  logic [NumIntr-1:0] event_d;
  logic [NumIntr-1:0] state_q;
  logic               tx_busy_q;
  logic               rx_valid_q;

  // tx_empty waits for the last frame to finish, not for the FIFO pop
  assign event_d[IntrTxEmpty] = stat.tx_idle & tx_busy_q;
  assign event_d[IntrRxWmark] = stat.rx_valid & ~rx_valid_q;
  assign event_d[IntrRxOvf]   = stat.rx_push & stat.rx_full;
  assign event_d[IntrRxFrame] = stat.rx_frame_err;

  // a new event wins over a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= '0;
      tx_busy_q  <= 1'b0;
      rx_valid_q <= 1'b0;
    end else begin
      state_q    <= (state_q & ~intr_clr_i) | event_d;
      tx_busy_q  <= stat.tx_busy;
      rx_valid_q <= stat.rx_valid;
    end
  end

  assign intr_state_o = state_q;
  assign intr_o       = |(state_q & intr_enable_i);

endmodule

// File: src/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  logic       tick_i,
  input  logic       line_i,
  output logic       valid_o,
  output logic       frame_err_o,
  output logic [7:0] data_o,
  output logic       idle_o
);

  rx_state_e  state_q;
  logic [3:0] tick_cnt_q;
  logic [2:0] bit_cnt_q;
  logic [7:0] shift_q;
  logic       line_q;
  logic       mid_bit;

  assign idle_o  = (state_q == RX_IDLE);
  assign data_o  = shift_q;

  // tick count restarts at the start edge, so tick 8 lands mid-bit
  assign mid_bit = tick_i & (tick_cnt_q == 4'd7);

  always_ff @(posedge clk_i) begin
    if (mid_bit && state_q == RX_DATA) begin
      shift_q <= {line_i, shift_q[7:1]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= RX_IDLE;
      tick_cnt_q  <= '0;
      bit_cnt_q   <= '0;
      line_q      <= 1'b1;
      valid_o     <= 1'b0;
      frame_err_o <= 1'b0;
    end else begin
      line_q      <= line_i;
      valid_o     <= 1'b0;
      frame_err_o <= 1'b0;
      if (!en_i) begin
        state_q <= RX_IDLE;
      end else if (state_q == RX_IDLE) begin
        tick_cnt_q <= '0;
        bit_cnt_q  <= '0;
        // falling edge only, a line stuck low after a bad stop bit is ignored
        if (line_q && !line_i) begin
          state_q <= RX_START;
        end
      end else if (tick_i) begin
        tick_cnt_q <= tick_cnt_q + 4'd1;
        if (mid_bit) begin
          case (state_q)
            RX_START: begin
              if (line_i) begin
                state_q <= RX_IDLE;
              end
            end
            RX_STOP: begin
              valid_o     <= line_i;
              frame_err_o <= ~line_i;
              state_q     <= RX_IDLE;
            end
            default: ;
          endcase
        end
        if (tick_cnt_q == 4'hf) begin
          case (state_q)
            RX_START: state_q <= RX_DATA;
            RX_DATA: begin
              bit_cnt_q <= bit_cnt_q + 3'd1;
              if (bit_cnt_q == 3'd7) begin
                state_q <= RX_STOP;
              end
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       tick_i,
  input  logic       start_i,
  input  logic [7:0] data_i,
  output logic       idle_o,
  output logic       bit_o
);

  tx_state_e  state_q;
  logic [7:0] shift_q;
  logic [3:0] tick_cnt_q;
  logic [2:0] bit_cnt_q;
  logic       bit_q;

  assign idle_o = (state_q == TX_IDLE);
  assign bit_o  = bit_q;

  // byte loaded on start, shifted out LSB first
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      shift_q <= data_i;
    end else if (tick_i && state_q == TX_DATA && tick_cnt_q == 4'hf) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // each bit starts on tick 0 and lasts 16 ticks
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= TX_IDLE;
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      bit_q      <= 1'b1;
    end else if (state_q == TX_IDLE) begin
      tick_cnt_q <= '0;
      bit_cnt_q  <= '0;
      if (start_i) begin
        state_q <= TX_START;
      end
    end else if (tick_i) begin
      tick_cnt_q <= tick_cnt_q + 4'd1;
      if (tick_cnt_q == 4'd0) begin
        case (state_q)
          TX_START: bit_q <= 1'b0;
          TX_DATA:  bit_q <= shift_q[0];
          default:  bit_q <= 1'b1;
        endcase
      end
      if (tick_cnt_q == 4'hf) begin
        case (state_q)
          TX_START: state_q <= TX_DATA;
          TX_DATA: begin
            bit_cnt_q <= bit_cnt_q + 3'd1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= TX_STOP;
            end
          end
          default:  state_q <= TX_IDLE;
        endcase
      end
    end
  end

  a_start_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> idle_o)
    else $error("[FAIL] %0t transmit start while a frame is in progress", $time);

endmodule

// File: src/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clr_i,
  input  logic                         push_i,
  input  logic [7:0]                   data_i,
  input  logic                         pop_i,
  output logic [7:0]                   data_o,
  output logic                         valid_o,
  output logic                         full_o,
  output logic [$clog2(FifoDepth):0]   level_o
);

  localparam int AddrW = $clog2(FifoDepth);
  localparam int LvlW  = AddrW + 1;

  logic [7:0]       mem_q [FifoDepth];
  logic [AddrW-1:0] wptr_q;
  logic [AddrW-1:0] rptr_q;
  logic [LvlW-1:0]  level_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (level_q == LvlW'(FifoDepth));
  assign valid_o = (level_q != '0);
  assign level_o = level_q;
  assign data_o  = mem_q[rptr_q];

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wptr_q] <= data_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (clr_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      level_q <= level_q + LvlW'(do_push) - LvlW'(do_pop);
    end
  end

  // level stays within the depth and in step with the pointer distance
  a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    level_q <= LvlW'(FifoDepth) && (wptr_q - rptr_q) == level_q[AddrW-1:0])
    else $error("[FAIL] %0t FIFO level out of step with its pointers", $time);

endmodule

// File: src/uart_stat_if.sv
`timescale 1ns/1ps

interface uart_stat_if #(
  parameter int FifoDepth = 8
);

  localparam int LvlW = $clog2(FifoDepth) + 1;

  // RX FIFO head
  logic [7:0]      rx_rdata;
  logic            rx_valid;

  logic            tx_full;
  logic            rx_full;
  logic [LvlW-1:0] tx_level;
  logic [LvlW-1:0] rx_level;

  // line status, tx_idle also covers an empty TX FIFO
  logic            tx_idle;
  logic            rx_idle;
  logic            tx_busy;

  // receive engine events
  logic            rx_push;
  logic            rx_frame_err;

  modport core (
    output rx_rdata, rx_valid, tx_full, rx_full, tx_level, rx_level,
           tx_idle, rx_idle, tx_busy, rx_push, rx_frame_err
  );

  modport dec (
    input rx_rdata, rx_valid, tx_full, rx_full, tx_level, rx_level, tx_idle, rx_idle
  );

  modport irq (
    input rx_valid, rx_full, tx_idle, tx_busy, rx_push, rx_frame_err
  );

endinterface

// File: src/uart_ctrl_if.sv
`timescale 1ns/1ps

interface uart_ctrl_if;

  // static configuration from CTRL
  logic        tx_en;
  logic        rx_en;
  logic        sys_lpbk;
  logic [15:0] nco;

  // single-cycle FIFO commands
  logic        tx_push;
  logic [7:0]  tx_wdata;
  logic        rx_pop;
  logic        tx_clr;
  logic        rx_clr;

  modport dec (
    output tx_en, rx_en, sys_lpbk, nco, tx_push, tx_wdata, rx_pop, tx_clr, rx_clr
  );

  modport core (
    input tx_en, rx_en, sys_lpbk, nco, tx_push, tx_wdata, rx_pop, tx_clr, rx_clr
  );

endinterface

// File: src/uart_pkg.sv
package uart_pkg;

  // width of the NCO increment and accumulator
  parameter int NcoWidth = 16;

  // register byte addresses on the APB port
  typedef enum logic [7:0] {
    CTRL        = 8'h00,
    STATUS      = 8'h04,
    WDATA       = 8'h08,
    RDATA       = 8'h0C,
    FIFO_CTRL   = 8'h10,
    INTR_STATE  = 8'h14,
    INTR_ENABLE = 8'h18,
    FIFO_STATUS = 8'h1C
  } uart_reg_e;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

  // bit positions in INTR_STATE and INTR_ENABLE
  parameter int IntrTxEmpty = 0;
  parameter int IntrRxWmark = 1;
  parameter int IntrRxOvf   = 2;
  parameter int IntrRxFrame = 3;
  parameter int NumIntr     = 4;

endpackage
